//--- filelist.f
+incdir+common
common/spi_pkg.sv
spi_phy/spi_shift_engine.sv
logic/spi_cmd_sequencer.sv
logic/spi_master_top.sv
verification/spi_slave_model.sv
verification/spi_master_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the SPI master testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module spi_master_tb \
	-o spi_master_sim || { echo "Verilator build failed"; exit 1; }

./obj_dir/spi_master_sim > sim.log 2>&1
cat sim.log

grep -q "Done: no errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- verification/spi_master_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_master_tb;

	import spi_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int ACK_TIMEOUT  = 2000;
	localparam int NUM_CMDS     = 80;

	logic                   clk;
	logic                   rst;
	logic                   cmd_req;
	spi_cmd_e               cmd_op;
	logic [`SPI_DIV_W-1:0]  cmd_data;
	logic                   cmd_ack;
	logic [`SPI_DATA_W-1:0] rsp_data;
	logic                   spi_sck;
	logic                   spi_mosi;
	logic                   spi_miso;
	logic                   spi_cs_n;

	//////////////////////////////////////////////////////////////////////
	// Reference model state

	logic [31:0]            rng;
	// Last byte sent, the device answers with its complement
	logic [`SPI_DATA_W-1:0] prev_tx;
	logic [`SPI_DATA_W-1:0] exp_rsp;
	logic                   exp_cs_n;
	// Divider after the clamp
	logic [`SPI_DIV_W-1:0]  exp_div;
	logic                   have_rsp;
	logic [2:0]             pick;

	// SCK pulse measurement, in clk cycles
	logic                   mon_on    = 1'b0;
	int                     high_run  = 0;
	int                     last_high = 0;
	int                     pulse_cnt = 0;

	spi_master_top #(
		.SAMPLE_FALLING (1'b0)
	) dut0 (
		.clk      (clk),
		.rst      (rst),
		.cmd_req  (cmd_req),
		.cmd_op   (cmd_op),
		.cmd_data (cmd_data),
		.cmd_ack  (cmd_ack),
		.rsp_data (rsp_data),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.spi_cs_n (spi_cs_n)
	);

	// Answers each byte with the complement of the one before
	spi_slave_model slave0 (
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.spi_cs_n (spi_cs_n),
		.spi_miso (spi_miso)
	);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers and compare tasks

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_byte(input string sig, input logic [`SPI_DATA_W-1:0] got,
			input logic [`SPI_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL time=%0t signal=%s got=0x%02h expected=0x%02h", $time, sig, got, exp);
			abort_run();
		end
	endtask

	// Chip select and other single wires
	task automatic check_bit(input string sig, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL time=%0t signal=%s got=%b expected=%b", $time, sig, got, exp);
			abort_run();
		end
	endtask

	task automatic check_cycles(input string sig, input int got, input int exp);
		if (got != exp) begin
			$display("FAIL time=%0t signal=%s got=%0d expected=%0d", $time, sig, got, exp);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// SCK monitor, samples on the falling clk edge

	always @(negedge clk) begin
		if (mon_on) begin
			// Idle bus keeps SCK low
			if (spi_cs_n) begin
				check_bit("spi_sck", spi_sck, 1'b0);
			end
			if (spi_sck) begin
				high_run = high_run + 1;
			end else if (high_run != 0) begin
				last_high = high_run;
				pulse_cnt = pulse_cnt + 1;
				high_run  = 0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Host side of the four-phase handshake

	task automatic run_command(input spi_cmd_e op, input logic [`SPI_DIV_W-1:0] data,
			output logic [`SPI_DATA_W-1:0] got_rsp, output logic got_cs_n);
		int wait_cnt;
		int hold;
		rng  = xorshift32(rng);
		hold = int'(rng % 4);
		// Idle gap, ack must stay low without a request
		repeat (int'(rng[9:8]) + 1) begin
			@(negedge clk);
			check_bit("cmd_ack", cmd_ack, 1'b0);
		end
		cmd_op   = op;
		cmd_data = data;
		cmd_req  = 1'b1;
		wait_cnt = 0;
		while (cmd_ack !== 1'b1) begin
			@(negedge clk);
			wait_cnt = wait_cnt + 1;
			if (wait_cnt > ACK_TIMEOUT) begin
				$display("Timeout: cmd_ack never rose for command %s", op.name());
				abort_run();
			end
		end
		got_rsp  = rsp_data;
		got_cs_n = spi_cs_n;
		// Stalled host, ack and chip select must not move
		repeat (hold) begin
			@(negedge clk);
			check_bit("cmd_ack", cmd_ack, 1'b1);
			check_bit("spi_cs_n", spi_cs_n, got_cs_n);
		end
		cmd_req  = 1'b0;
		wait_cnt = 0;
		while (cmd_ack !== 1'b0) begin
			@(negedge clk);
			wait_cnt = wait_cnt + 1;
			if (wait_cnt > ACK_TIMEOUT) begin
				$display("Timeout: cmd_ack stayed high after cmd_req fell");
				abort_run();
			end
		end
	endtask

	// One command through the DUT and the model
	task automatic issue(input spi_cmd_e op, input logic [`SPI_DIV_W-1:0] data);
		logic [`SPI_DATA_W-1:0] got_rsp;
		logic                   got_cs_n;
		int                     pulses_before;
		pulses_before = pulse_cnt;
		run_command(op, data, got_rsp, got_cs_n);
		case (op)
			CMD_SET_DIV: begin
				exp_div = (data < `SPI_DIV_MIN) ? `SPI_DIV_W'(`SPI_DIV_MIN) : data;
			end
			CMD_CS_RELEASE: begin
				exp_cs_n = 1'b1;
			end
			default: begin
				exp_rsp  = ~prev_tx;
				prev_tx  = data[`SPI_DATA_W-1:0];
				exp_cs_n = (op == CMD_XFER_LAST);
				have_rsp = 1'b1;
				check_cycles("spi_sck pulses", pulse_cnt - pulses_before, `SPI_DATA_W);
				check_cycles("spi_sck high time", last_high, int'(exp_div >> 1) + 1);
			end
		endcase
		check_bit("spi_cs_n", got_cs_n, exp_cs_n);
		// Response holds between transfers
		if (have_rsp) begin
			check_byte("rsp_data", got_rsp, exp_rsp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		rst      = 1'b1;
		cmd_req  = 1'b0;
		cmd_op   = CMD_SET_DIV;
		cmd_data = '0;
		rng      = 32'd73;
		prev_tx  = '0;
		exp_rsp  = '0;
		exp_cs_n = 1'b1;
		exp_div  = `SPI_DIV_W'(`SPI_DIV_RESET);
		have_rsp = 1'b0;
		pick     = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_bit("spi_cs_n", spi_cs_n, 1'b1);
		check_bit("spi_sck", spi_sck, 1'b0);
		check_bit("spi_mosi", spi_mosi, 1'b0);
		check_bit("cmd_ack", cmd_ack, 1'b0);
		@(posedge clk);
		mon_on = 1'b1;

		// Reset divider first, then the two values that clamp
		issue(CMD_XFER, `SPI_DIV_W'(16'h00a5));
		issue(CMD_SET_DIV, '0);
		issue(CMD_XFER, `SPI_DIV_W'(16'h003c));
		issue(CMD_SET_DIV, `SPI_DIV_W'(1));
		issue(CMD_XFER_LAST, `SPI_DIV_W'(16'h00c3));

		for (int i = 0; i < NUM_CMDS; i++) begin
			rng  = xorshift32(rng);
			pick = rng[2:0];
			rng  = xorshift32(rng);
			case (pick)
				3'd0: issue(CMD_SET_DIV, `SPI_DIV_W'(rng % 21));
				3'd1: issue(CMD_CS_RELEASE, rng[`SPI_DIV_W-1:0]);
				3'd2, 3'd3: issue(CMD_XFER_LAST, rng[`SPI_DIV_W-1:0]);
				default: issue(CMD_XFER, rng[`SPI_DIV_W-1:0]);
			endcase
		end
		issue(CMD_CS_RELEASE, '0);

		// Last byte on MOSI never comes back as a response
		check_byte("spi_mosi", slave0.last_rx, prev_tx);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/spi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_slave_model (
	input  wire  spi_sck,
	input  wire  spi_mosi,
	input  wire  spi_cs_n,
	output logic spi_miso
);

	// Bits arriving on MOSI, MSB first
	logic [`SPI_DATA_W-1:0] rx_shreg = '0;
	// Answer being shifted out, top bit is on MISO
	logic [`SPI_DATA_W-1:0] tx_shreg = '1;
	// Previous complete byte, starts from zero
	logic [`SPI_DATA_W-1:0] last_rx  = '0;
	logic                   cs_prev  = 1'b1;
	int                     bit_cnt  = 0;

	initial begin
		spi_miso = 1'b0;
	end

	always @(posedge spi_sck or negedge spi_sck or posedge spi_cs_n or negedge spi_cs_n) begin
		if (spi_cs_n !== 1'b0) begin
			// Deselected, nothing on the bus concerns this device
			bit_cnt = 0;
		end else if (cs_prev) begin
			// Select just fell, first bit of the answer goes out now
			tx_shreg = ~last_rx;
			spi_miso = tx_shreg[`SPI_DATA_W-1];
			bit_cnt  = 0;
		end else if (spi_sck) begin
			// Rising SCK, sample MOSI
			rx_shreg = {rx_shreg[`SPI_DATA_W-2:0], spi_mosi};
			bit_cnt  = bit_cnt + 1;
			if (bit_cnt == `SPI_DATA_W) begin
				// Byte complete, next answer is ready before the next launch
				last_rx  = rx_shreg;
				tx_shreg = ~rx_shreg;
				spi_miso = tx_shreg[`SPI_DATA_W-1];
				bit_cnt  = 0;
			end
		end else if (bit_cnt != 0) begin
			// Falling SCK inside a byte, move to the next bit
			tx_shreg = {tx_shreg[`SPI_DATA_W-2:0], 1'b0};
			spi_miso = tx_shreg[`SPI_DATA_W-1];
		end
		cs_prev = spi_cs_n;
	end

endmodule

`default_nettype wire

//--- logic/spi_master_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_master_top #(
	// Set when the remote device samples on falling SCK
	parameter bit SAMPLE_FALLING = 1'b0
) (
	input  wire                    clk,
	input  wire                    rst,

	// Host command port
	input  wire                    cmd_req,
	input  wire spi_pkg::spi_cmd_e cmd_op,
	input  wire [`SPI_DIV_W-1:0]   cmd_data,
	output logic                   cmd_ack,
	output logic [`SPI_DATA_W-1:0] rsp_data,

	// SPI pins
	output logic                   spi_sck,
	output logic                   spi_mosi,
	input  wire                    spi_miso,
	output logic                   spi_cs_n
);

	//////////////////////////////////////////////////////////////////////
	// Sequencer to engine

	logic [`SPI_DIV_W-1:0]  clkdiv;
	logic                   shift_start;
	logic [`SPI_DATA_W-1:0] tx_byte;
	logic                   shift_done;
	logic [`SPI_DATA_W-1:0] rx_byte;

	// Host handshake, divider and chip select
	spi_cmd_sequencer seq0 (
		.clk         (clk),
		.rst         (rst),
		.cmd_req     (cmd_req),
		.cmd_op      (cmd_op),
		.cmd_data    (cmd_data),
		.cmd_ack     (cmd_ack),
		.rsp_data    (rsp_data),
		.spi_cs_n    (spi_cs_n),
		.clkdiv      (clkdiv),
		.shift_start (shift_start),
		.tx_byte     (tx_byte),
		.shift_done  (shift_done),
		.rx_byte     (rx_byte)
	);

	// Byte shifter and SCK generation
	spi_shift_engine #(
		.SAMPLE_FALLING (SAMPLE_FALLING)
	) phy0 (
		.clk         (clk),
		.rst         (rst),
		.clkdiv      (clkdiv),
		.shift_start (shift_start),
		.tx_byte     (tx_byte),
		.shift_done  (shift_done),
		.rx_byte     (rx_byte),
		.spi_sck     (spi_sck),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso)
	);

endmodule

`default_nettype wire

//--- logic/spi_cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_cmd_sequencer (
	input  wire                    clk,
	input  wire                    rst,

	// Host side, four-phase req/ack
	input  wire                    cmd_req,
	input  wire spi_pkg::spi_cmd_e cmd_op,
	input  wire [`SPI_DIV_W-1:0]   cmd_data,
	output logic                   cmd_ack,
	output logic [`SPI_DATA_W-1:0] rsp_data,

	// Chip select, active low
	output logic                   spi_cs_n,

	// Shift engine control
	output logic [`SPI_DIV_W-1:0]  clkdiv,
	output logic                   shift_start,
	output logic [`SPI_DATA_W-1:0] tx_byte,
	input  wire                    shift_done,
	input  wire [`SPI_DATA_W-1:0]  rx_byte
);

	import spi_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Divider limits

	localparam logic [`SPI_DIV_W-1:0] DIV_MIN   = `SPI_DIV_W'(`SPI_DIV_MIN);
	localparam logic [`SPI_DIV_W-1:0] DIV_RESET = `SPI_DIV_W'(`SPI_DIV_RESET);

	seq_state_e               state;

	// Opcode held for the length of the command
	spi_cmd_e                 op_q;

	// Counts the chip select setup time, one half period
	logic [`SPI_DIV_W-2:0]    setup_cnt;

	// Divider value after clamping
	logic [`SPI_DIV_W-1:0]    div_wr;

	// New command accepted this cycle
	logic                     req_start;

	// Too-small dividers would stall SCK generation
	assign div_wr = (cmd_data < DIV_MIN) ? DIV_MIN : cmd_data;

	assign req_start = (state == S_IDLE) && cmd_req;

	//////////////////////////////////////////////////////////////////////
	// Command FSM

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= S_IDLE;
			cmd_ack     <= 1'b0;
			spi_cs_n    <= 1'b1;
			clkdiv      <= DIV_RESET;
			shift_start <= 1'b0;
		end else begin
			// Launch is a single-cycle pulse
			shift_start <= 1'b0;

			case (state)
				S_IDLE: begin
					if (cmd_req) begin
						case (cmd_op)
							CMD_SET_DIV: begin
								clkdiv <= div_wr;
								state  <= S_ACK;
							end
							CMD_CS_RELEASE: begin
								state <= S_ACK;
							end
							CMD_XFER, CMD_XFER_LAST: begin
								if (spi_cs_n) begin
									// Device needs a half period after select
									spi_cs_n <= 1'b0;
									state    <= S_CS_SETUP;
								end else begin
									// Already selected, shift right away
									shift_start <= 1'b1;
									state       <= S_SHIFT;
								end
							end
						endcase
					end
				end

				S_CS_SETUP: begin
					if (setup_cnt == clkdiv[`SPI_DIV_W-1:1]) begin
						shift_start <= 1'b1;
						state       <= S_SHIFT;
					end
				end

				S_SHIFT: begin
					// Ack follows done by one cycle
					if (shift_done) begin
						cmd_ack <= 1'b1;
						if (op_q == CMD_XFER_LAST) begin
							spi_cs_n <= 1'b1;
						end
						state <= S_WAIT_REQ_LOW;
					end
				end

				S_ACK: begin
					cmd_ack <= 1'b1;
					// Release and ack land on the same edge
					if (op_q == CMD_CS_RELEASE) begin
						spi_cs_n <= 1'b1;
					end
					state <= S_WAIT_REQ_LOW;
				end

				S_WAIT_REQ_LOW: begin
					// Host holding req stalls here
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
						state   <= S_IDLE;
					end
				end

				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Command payload and response

	always_ff @(posedge clk) begin
		if (req_start) begin
			op_q    <= cmd_op;
			tx_byte <= cmd_data[`SPI_DATA_W-1:0];
		end

		// Restarts from zero every time select is asserted
		if (state == S_CS_SETUP) begin
			setup_cnt <= setup_cnt + 1'b1;
		end else begin
			setup_cnt <= '0;
		end

		// Response only changes when a transfer completes
		if ((state == S_SHIFT) && shift_done) begin
			rsp_data <= rx_byte;
		end
	end

endmodule

`default_nettype wire

//--- spi_phy/spi_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_shift_engine #(
	// Set when the remote device samples on falling SCK
	parameter bit SAMPLE_FALLING = 1'b0
) (
	input  wire                    clk,
	input  wire                    rst,

	// Half period length is clkdiv/2 + 1 cycles
	input  wire [`SPI_DIV_W-1:0]   clkdiv,

	// Launch and result
	input  wire                    shift_start,
	input  wire [`SPI_DATA_W-1:0]  tx_byte,
	output logic                   shift_done,
	output logic [`SPI_DATA_W-1:0] rx_byte,

	// SPI pins
	output logic                   spi_sck,
	output logic                   spi_mosi,
	input  wire                    spi_miso
);

	//////////////////////////////////////////////////////////////////////
	// Half period bookkeeping

	// Cycle counter compares against clkdiv/2, one bit narrower
	localparam int HALF_CNT_W = `SPI_DIV_W - 1;

	// Two half periods per bit, then one trailing half period
	localparam int HALF_TOTAL = 2 * `SPI_DATA_W + 1;
	localparam int HALF_W     = $clog2(HALF_TOTAL + 1);

	// Half period after which SCK is parked low
	localparam logic [HALF_W-1:0] HALF_IDLE = HALF_W'(2 * `SPI_DATA_W);
	// Half period after which done fires
	localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(HALF_TOTAL);

	logic                    active;
	logic [HALF_CNT_W-1:0]   clk_cnt;
	logic [HALF_W-1:0]       half_cnt;
	logic [HALF_W-1:0]       half_nxt;
	logic                    half_end;

	// MSB goes out at launch so only the lower bits wait here
	logic [`SPI_DATA_W-2:0]  tx_shreg;
	logic [`SPI_DATA_W-1:0]  rx_shreg;

	// Last cycle of the current half period
	assign half_end = (clk_cnt == clkdiv[`SPI_DIV_W-1:1]);

	// Index of the half period that ends now, counting from 1
	assign half_nxt = half_cnt + 1'b1;

	//////////////////////////////////////////////////////////////////////
	// SCK, MOSI and done

	always_ff @(posedge clk) begin
		if (rst) begin
			active     <= 1'b0;
			clk_cnt    <= '0;
			half_cnt   <= '0;
			spi_sck    <= 1'b0;
			spi_mosi   <= 1'b0;
			shift_done <= 1'b0;
		end else begin
			shift_done <= 1'b0;

			if (shift_start) begin
				active   <= 1'b1;
				clk_cnt  <= '0;
				half_cnt <= '0;

				// Falling-edge devices see SCK high first
				spi_sck  <= SAMPLE_FALLING;

				// First bit is on the wire before any edge
				spi_mosi <= tx_byte[`SPI_DATA_W-1];
			end else if (active) begin
				if (half_end) begin
					clk_cnt  <= '0;
					half_cnt <= half_nxt;

					if (half_nxt == HALF_LAST) begin
						// Trailing half period is over
						active     <= 1'b0;
						shift_done <= 1'b1;
					end else if (half_nxt == HALF_IDLE) begin
						// All bits sampled, park SCK low
						spi_sck <= 1'b0;
					end else begin
						spi_sck <= ~spi_sck;

						// Even edges are the launch edges for the remote side
						if (!half_nxt[0]) begin
							spi_mosi <= tx_shreg[`SPI_DATA_W-2];
						end
					end
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Shift registers

	always_ff @(posedge clk) begin
		if (shift_start) begin
			tx_shreg <= tx_byte[`SPI_DATA_W-2:0];
		end else if (active && half_end && (half_nxt < HALF_IDLE)) begin
			if (half_nxt[0]) begin
				// Sampling edge, MISO has been stable for a half period
				rx_shreg <= {rx_shreg[`SPI_DATA_W-2:0], spi_miso};
			end else begin
				// Next bit moves up to the MSB position
				tx_shreg <= {tx_shreg[`SPI_DATA_W-3:0], 1'b0};
			end
		end

		// Result appears together with done and stays until the next byte
		if (active && half_end && (half_nxt == HALF_LAST)) begin
			rx_byte <= rx_shreg;
		end
	end

endmodule

`default_nettype wire

//--- common/spi_pkg.sv
`default_nettype none

package spi_pkg;

	//////////////////////////////////////////////////////////////////////
	// Host command opcodes

	// Encoding is fixed because the host side drives these bits directly
	typedef enum logic [1:0] {
		// Write the SCK divider from cmd_data
		CMD_SET_DIV    = 2'd0,
		// One byte, chip select stays low afterwards
		CMD_XFER       = 2'd1,
		// One byte, chip select released with the ack
		CMD_XFER_LAST  = 2'd2,
		// Drop chip select, no bus activity
		CMD_CS_RELEASE = 2'd3
	} spi_cmd_e;

	//////////////////////////////////////////////////////////////////////
	// Command sequencer states

	typedef enum logic [2:0] {
		S_IDLE         = 3'd0,
		S_CS_SETUP     = 3'd1,
		S_SHIFT        = 3'd2,
		S_ACK          = 3'd3,
		S_WAIT_REQ_LOW = 3'd4
	} seq_state_e;

endpackage

`default_nettype wire

//--- common/spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Width of one SPI transfer
`define SPI_DATA_W 8

// Width of the SCK divider register
`define SPI_DIV_W 16

// Smallest divider accepted, smaller writes are raised to this
`define SPI_DIV_MIN 2

// Divider loaded by reset
`define SPI_DIV_RESET 8

`endif
